/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rv32i_core_tb -f verilog.f -o rv32i_sim \
    || exit 1
out="$(./obj_dir/rv32i_sim)"
echo "$out"
echo "$out" | grep -q "Verification passed" && exit 0 || exit 1

/* sim/rv32i_core_assertions.sv */
`default_nettype none

module rv32i_core_assertions (
    input  wire logic               clk,
    input  wire logic               arst_n_i,
    input  wire logic               data_we_i,
    input  wire logic               redirect_i,
    input  wire logic               stall_i,
    input  wire rv32i_pkg::if_id_t  if_id_i,
    input  wire rv32i_pkg::id_ex_t  id_ex_i,
    input  wire rv32i_pkg::ex_mem_t ex_mem_i
);

    we_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        !$isunknown(data_we_i))
        else $error("data_we_o is unknown");

    // Operand from x0 or an unused port
    x0_rs1_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
        (id_ex_i.rs1 == 5'd0) |-> (id_ex_i.op_a == 32'd0))
        else $error("x0 read on port A is not zero");

    x0_rs2_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
        (id_ex_i.rs2 == 5'd0) |-> (id_ex_i.op_b == 32'd0))
        else $error("x0 read on port B is not zero");

    //////////////////////////////////////////////////
    // Flush and bubble
    //////////////////////////////////////////////////

    redirect_flush: assert property (@(posedge clk) disable iff (!arst_n_i)
        redirect_i |=> (!id_ex_i.valid && (if_id_i.instr.ri.opcode == 7'd0)))
        else $error("instruction survived a redirect");

    flushed_no_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        $past(redirect_i, 2) |-> !ex_mem_i.valid)
        else $error("flushed instruction reached the memory stage");

    // A stall only ever waits on a valid load that moves on to memory
    stall_bubble: assert property (@(posedge clk) disable iff (!arst_n_i)
        (stall_i && !redirect_i) |=> (!id_ex_i.valid && ex_mem_i.valid && ex_mem_i.load))
        else $error("stall did not hold back the dependent of a load");

endmodule

bind rv32i_core rv32i_core_assertions u_assertions (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .data_we_i  (data_we_o),
    .redirect_i (redirect),
    .stall_i    (stall),
    .if_id_i    (if_id),
    .id_ex_i    (id_ex),
    .ex_mem_i   (ex_mem)
);

`default_nettype wire

/* sim/rv32i_core_tb.sv */
`default_nettype none

`include "rv32i_config.svh"

module rv32i_core_tb;

    localparam int BODY_LEN = 200;
    localparam int PROG_LEN = BODY_LEN + 32;
    localparam logic [31:0] HALT_PC = `RV_RESET_PC + 32'((BODY_LEN + 31) * 4);

    localparam logic [2:0] K_LUI = 3'd0;
    localparam logic [2:0] K_OP  = 3'd1;
    localparam logic [2:0] K_OPI = 3'd3;
    localparam logic [2:0] K_LW  = 3'd4;
    localparam logic [2:0] K_SW  = 3'd5;
    localparam logic [2:0] K_BR  = 3'd6;
    localparam logic [2:0] K_JAL = 3'd7;

    logic        clk;
    logic        arst_n_i;
    logic [31:0] instr_i;
    logic [31:0] data_rdata_i;
    logic [31:0] instr_addr_o;
    logic [31:0] data_addr_o;
    logic [31:0] data_wdata_o;
    logic        data_we_o;
    logic [31:0] fetch_off;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:63];
    logic [31:0] ref_mem [0:63];
    logic [31:0] ref_regs [0:31];

    // Program fields with one entry per instruction
    logic [2:0]  kind_f [0:PROG_LEN-1];
    logic [4:0]  rd_f [0:PROG_LEN-1];
    logic [4:0]  rs1_f [0:PROG_LEN-1];
    logic [4:0]  rs2_f [0:PROG_LEN-1];
    logic [2:0]  sel_f [0:PROG_LEN-1];
    logic [31:0] imm_f [0:PROG_LEN-1];

    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          stores_seen;
    int          stores_expected;

    rv32i_core dut (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .instr_i      (instr_i),
        .data_rdata_i (data_rdata_i),
        .instr_addr_o (instr_addr_o),
        .data_addr_o  (data_addr_o),
        .data_wdata_o (data_wdata_o),
        .data_we_o    (data_we_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Memories
    //////////////////////////////////////////////////

    assign fetch_off    = instr_addr_o - `RV_RESET_PC;
    assign instr_i      = imem[fetch_off[9:2]];
    assign data_rdata_i = dmem[data_addr_o[7:2]];

    function automatic logic [31:0] fill_word(input int w);
        return (32'(w) * 32'h9e37_79b9) ^ 32'hc3a5_0f0f;
    endfunction

    // Pattern loaded while reset is held
    always @(posedge clk) begin
        if (!arst_n_i) begin
            for (int w = 0; w < 64; w++) begin
                dmem[w] <= fill_word(w);
            end
        end else if (data_we_o) begin
            dmem[data_addr_o[7:2]] <= data_wdata_o;
        end
    end

    //////////////////////////////////////////////////
    // Random program
    //////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Selector order ADD SUB SLL SLT XOR SRL OR AND
    function automatic logic [2:0] funct3_of(input logic [2:0] sel);
        case (sel)
            3'd0, 3'd1: return 3'b000;
            3'd2:       return 3'b001;
            3'd3:       return 3'b010;
            default:    return sel;
        endcase
    endfunction

    function automatic logic [31:0] encode(input int idx);
        logic [31:0] im;
        logic [4:0]  d;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [2:0]  sel;
        im  = imm_f[idx];
        d   = rd_f[idx];
        s1  = rs1_f[idx];
        s2  = rs2_f[idx];
        sel = sel_f[idx];
        case (kind_f[idx])
            K_LUI: return {im[31:12], d, 7'b0110111};
            K_OP:  return {1'b0, sel == 3'd1, 5'b0, s2, s1, funct3_of(sel), d, 7'b0110011};
            K_OPI: return {im[11:0], s1, funct3_of(sel), d, 7'b0010011};
            K_LW:  return {im[11:0], 5'd0, 3'b010, d, 7'b0000011};
            K_SW:  return {im[11:5], s2, 5'd0, 3'b010, im[4:0], 7'b0100011};
            K_BR:  return {im[12], im[10:5], s2, s1, 2'b00, sel[0], im[4:1], im[11],
                           7'b1100011};
            default: return {im[20], im[10:1], im[11], im[19:12], d, 7'b1101111};
        endcase
    endfunction

    task automatic build_program();
        logic [2:0]  k;
        logic [31:0] r;
        int          idx;
        for (int i = 0; i < BODY_LEN; i++) begin
            k = 3'(rand_bits(3));
            if (k == 3'd2) k = K_OP;
            // Forward targets stay inside the body
            if ((k == K_BR || k == K_JAL) && (i + 8 > BODY_LEN)) k = K_OPI;
            kind_f[i] = k;
            rd_f[i]   = 5'(rand_bits(3));
            rs1_f[i]  = 5'(rand_bits(3));
            rs2_f[i]  = 5'(rand_bits(3));
            sel_f[i]  = 3'(rand_bits(3));
            imm_f[i]  = '0;
            case (k)
                K_LUI: imm_f[i] = rand_bits(20) << 12;
                K_OPI: begin
                    if (sel_f[i] == 3'd1) sel_f[i] = 3'd0;
                    if (sel_f[i] == 3'd2 || sel_f[i] == 3'd5) begin
                        imm_f[i] = rand_bits(5);
                    end else begin
                        r        = rand_bits(12);
                        imm_f[i] = {{20{r[11]}}, r[11:0]};
                    end
                end
                K_LW, K_SW: begin
                    rs1_f[i] = 5'd0;
                    imm_f[i] = rand_bits(6) << 2;
                end
                K_BR, K_JAL: imm_f[i] = (32'd2 + rand_bits(3) % 32'd7) << 2;
                default: imm_f[i] = '0;
            endcase
        end
        // Dump of x1..x31, then JAL to itself
        for (int r5 = 1; r5 < 32; r5++) begin
            idx         = BODY_LEN + r5 - 1;
            kind_f[idx] = K_SW;
            rd_f[idx]   = 5'd0;
            rs1_f[idx]  = 5'd0;
            rs2_f[idx]  = 5'(r5);
            sel_f[idx]  = 3'd0;
            imm_f[idx]  = 32'(r5 * 4);
        end
        kind_f[PROG_LEN-1] = K_JAL;
        rd_f[PROG_LEN-1]   = 5'd0;
        rs1_f[PROG_LEN-1]  = 5'd0;
        rs2_f[PROG_LEN-1]  = 5'd0;
        sel_f[PROG_LEN-1]  = 3'd0;
        imm_f[PROG_LEN-1]  = '0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < PROG_LEN) ? encode(i) : 32'd0;
        end
    endtask

    //////////////////////////////////////////////////
    // ISA model
    //////////////////////////////////////////////////

    function automatic logic [31:0] alu_ref(input logic [2:0] sel, input logic [31:0] a,
                                            input logic [31:0] b);
        case (sel)
            3'd1:    return a - b;
            3'd2:    return a << b[4:0];
            3'd3:    return {31'b0, $signed(a) < $signed(b)};
            3'd4:    return a ^ b;
            3'd5:    return a >> b[4:0];
            3'd6:    return a | b;
            3'd7:    return a & b;
            default: return a + b;
        endcase
    endfunction

    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        int          idx;
        pc = `RV_RESET_PC;
        for (int r = 0; r < 32; r++) ref_regs[r] = '0;
        for (int w = 0; w < 64; w++) ref_mem[w] = fill_word(w);
        for (int step = 0; step < PROG_LEN && pc != HALT_PC; step++) begin
            idx     = int'((pc - `RV_RESET_PC) >> 2);
            a       = ref_regs[rs1_f[idx]];
            b       = ref_regs[rs2_f[idx]];
            addr    = a + imm_f[idx];
            res     = '0;
            pc_next = pc + 32'd4;
            case (kind_f[idx])
                K_LUI: res = imm_f[idx];
                K_OP:  res = alu_ref(sel_f[idx], a, b);
                K_OPI: res = alu_ref(sel_f[idx], a, imm_f[idx]);
                K_LW:  res = ref_mem[addr[7:2]];
                K_SW: begin
                    ref_mem[addr[7:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                K_BR: begin
                    if ((a == b) != sel_f[idx][0]) pc_next = pc + imm_f[idx];
                end
                default: begin
                    res     = pc + 32'd4;
                    pc_next = pc + imm_f[idx];
                end
            endcase
            if (kind_f[idx] != K_SW && kind_f[idx] != K_BR && rd_f[idx] != 5'd0) begin
                ref_regs[rd_f[idx]] = res;
            end
            pc = pc_next;
        end
        stores_expected = exp_addr.size();
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        if (arst_n_i && data_we_o) begin
            if (exp_addr.size() == 0) begin
                errors++;
                $display("At %0t the core stored to %h after all expected stores were seen",
                         $time, data_addr_o);
            end else begin
                check("data_addr_o", data_addr_o, exp_addr.pop_front());
                check("data_wdata_o", data_wdata_o, exp_data.pop_front());
            end
            stores_seen++;
        end
    end

    initial begin
        int          cycles;
        int          halt_hits;
        logic [31:0] prev_addr;
        arst_n_i    = 1'b0;
        lfsr        = 32'hf52f;
        errors      = 0;
        checks      = 0;
        stores_seen = 0;
        build_program();
        run_model();
        repeat (4) @(posedge clk);
        #1 arst_n_i = 1'b1;
        @(negedge clk);
        check("instr_addr_o", instr_addr_o, `RV_RESET_PC);
        prev_addr = instr_addr_o;
        halt_hits = 0;
        cycles    = 0;
        // Second entry into the halt address means the halt JAL has executed
        while (halt_hits < 2 && cycles < 5000) begin
            @(negedge clk);
            cycles++;
            if (instr_addr_o == HALT_PC && prev_addr != HALT_PC) halt_hits++;
            prev_addr = instr_addr_o;
        end
        if (halt_hits < 2) begin
            errors++;
            $display("Timeout: the core did not reach the halt loop within 5000 cycles");
        end
        check("store count", 32'(stores_seen), 32'(stores_expected));
        $display("Checks: %0d, stores: %0d, errors: %0d", checks, stores_seen, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verilog
verilog/rv32i_pkg.sv
verilog/fetch_stage.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/rv32i_core.sv
sim/rv32i_core_assertions.sv
sim/rv32i_core_tb.sv

/* verilog/decode_stage.sv */
`default_nettype none

module decode_stage (
    input  wire logic               clk,
    input  wire logic               arst_n_i,
    input  wire logic               stall_i,
    input  wire logic               flush_i,
    input  wire rv32i_pkg::if_id_t  if_id_i,
    input  wire rv32i_pkg::mem_wb_t wb_i,
    output rv32i_pkg::id_ex_t       id_ex_o,
    output logic [4:0]              rs1_o,
    output logic [4:0]              rs2_o
);

    rv32i_pkg::instr_u  ins;
    rv32i_pkg::id_ex_t  dec;
    rv32i_pkg::alu_op_e alu_op;
    logic        alu_ok;
    logic        use_rs1;
    logic        use_rs2;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;

    assign ins = if_id_i.instr;

    //////////////////////////////////////////////////
    // Immediates
    //////////////////////////////////////////////////

    assign imm_i = {{20{ins.ri.funct7[6]}}, ins.ri.funct7, ins.ri.rs2};
    assign imm_s = {{20{ins.sb.imm_hi[6]}}, ins.sb.imm_hi, ins.sb.imm_lo};
    assign imm_b = {{19{ins.sb.imm_hi[6]}}, ins.sb.imm_hi[6], ins.sb.imm_lo[0],
                    ins.sb.imm_hi[5:0], ins.sb.imm_lo[4:1], 1'b0};
    assign imm_j = {{11{ins.ri.funct7[6]}}, ins.ri.funct7[6], ins.ri.rs1, ins.ri.funct3,
                    ins.ri.rs2[0], ins.ri.funct7[5:0], ins.ri.rs2[4:1], 1'b0};
    assign imm_u = {ins.ri.funct7, ins.ri.rs2, ins.ri.rs1, ins.ri.funct3, 12'b0};

    // Only real source operands reach the hazard unit
    assign rs1_o = use_rs1 ? ins.ri.rs1 : 5'd0;
    assign rs2_o = use_rs2 ? ins.ri.rs2 : 5'd0;

    register_file u_regs (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_i      (rs1_o),
        .rs2_i      (rs2_o),
        .wb_i       (wb_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // OP and OP-IMM share funct3
    always_comb begin
        alu_ok = 1'b1;
        case (ins.ri.funct3)
            3'b000: begin
                if ((ins.ri.opcode == rv32i_pkg::OPC_OP) && ins.ri.funct7[5]) begin
                    alu_op = rv32i_pkg::ALU_SUB;
                end else begin
                    alu_op = rv32i_pkg::ALU_ADD;
                end
            end
            3'b001: alu_op = rv32i_pkg::ALU_SLL;
            3'b010: alu_op = rv32i_pkg::ALU_SLT;
            3'b100: alu_op = rv32i_pkg::ALU_XOR;
            3'b101: begin
                alu_op = rv32i_pkg::ALU_SRL;
                alu_ok = !ins.ri.funct7[5];
            end
            3'b110: alu_op = rv32i_pkg::ALU_OR;
            3'b111: alu_op = rv32i_pkg::ALU_AND;
            default: begin
                alu_op = rv32i_pkg::ALU_ADD;
                alu_ok = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////

    always_comb begin
        dec        = '0;
        dec.valid  = 1'b1;
        dec.rd     = ins.ri.rd;
        dec.pc     = if_id_i.pc;
        dec.alu_op = rv32i_pkg::ALU_ADD;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        case (ins.ri.opcode)
            rv32i_pkg::OPC_LUI: begin
                dec.lui       = 1'b1;
                dec.reg_write = 1'b1;
                dec.imm       = imm_u;
            end
            rv32i_pkg::OPC_OP: begin
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                dec.reg_write = 1'b1;
                dec.alu_op    = alu_op;
                dec.valid     = alu_ok;
            end
            rv32i_pkg::OPC_OP_IMM: begin
                use_rs1       = 1'b1;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.imm       = imm_i;
                dec.alu_op    = alu_op;
                dec.valid     = alu_ok;
            end
            rv32i_pkg::OPC_LOAD: begin
                use_rs1       = 1'b1;
                dec.use_imm   = 1'b1;
                dec.load      = 1'b1;
                dec.reg_write = 1'b1;
                dec.imm       = imm_i;
                dec.valid     = (ins.ri.funct3 == 3'b010);
            end
            rv32i_pkg::OPC_STORE: begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                dec.use_imm = 1'b1;
                dec.store   = 1'b1;
                dec.imm     = imm_s;
                dec.valid   = (ins.sb.funct3 == 3'b010);
            end
            rv32i_pkg::OPC_BRANCH: begin
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
                dec.branch = 1'b1;
                dec.bne    = ins.sb.funct3[0];
                dec.imm    = imm_b;
                dec.valid  = (ins.sb.funct3[2:1] == 2'b00);
            end
            rv32i_pkg::OPC_JAL: begin
                dec.jump      = 1'b1;
                dec.reg_write = 1'b1;
                dec.imm       = imm_j;
            end
            default: dec.valid = 1'b0;
        endcase
        dec.rs1  = rs1_o;
        dec.rs2  = rs2_o;
        dec.op_a = rs1_data;
        dec.op_b = rs2_data;
    end

    // Bubble on stall or flush
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o <= '0;
        end else if (flush_i || stall_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= dec;
        end
    end

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`default_nettype none

module execute_stage (
    input  wire logic                clk,
    input  wire logic                arst_n_i,
    input  wire rv32i_pkg::id_ex_t   id_ex_i,
    input  wire rv32i_pkg::fwd_sel_e fwd_a_i,
    input  wire rv32i_pkg::fwd_sel_e fwd_b_i,
    input  wire logic [31:0]         mem_fwd_i,
    input  wire logic [31:0]         wb_fwd_i,
    output rv32i_pkg::ex_mem_t       ex_mem_o,
    output logic                     redirect_o,
    output logic [31:0]              redirect_pc_o
);

    logic [31:0] opnd_a;
    logic [31:0] opnd_b;
    logic [31:0] alu_b;
    logic [31:0] alu_res;
    logic [31:0] result;
    logic        taken;

    function automatic logic [31:0] fwd_mux(input rv32i_pkg::fwd_sel_e sel,
                                            input logic [31:0] rf_val);
        case (sel)
            rv32i_pkg::FWD_MEM: return mem_fwd_i;
            rv32i_pkg::FWD_WB:  return wb_fwd_i;
            default:            return rf_val;
        endcase
    endfunction

    always_comb begin
        opnd_a = fwd_mux(fwd_a_i, id_ex_i.op_a);
        opnd_b = fwd_mux(fwd_b_i, id_ex_i.op_b);
    end

    assign alu_b = id_ex_i.use_imm ? id_ex_i.imm : opnd_b;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    always_comb begin
        case (id_ex_i.alu_op)
            rv32i_pkg::ALU_SUB: alu_res = opnd_a - alu_b;
            rv32i_pkg::ALU_AND: alu_res = opnd_a & alu_b;
            rv32i_pkg::ALU_OR:  alu_res = opnd_a | alu_b;
            rv32i_pkg::ALU_XOR: alu_res = opnd_a ^ alu_b;
            rv32i_pkg::ALU_SLT: alu_res = {31'b0, $signed(opnd_a) < $signed(alu_b)};
            rv32i_pkg::ALU_SLL: alu_res = opnd_a << alu_b[4:0];
            rv32i_pkg::ALU_SRL: alu_res = opnd_a >> alu_b[4:0];
            default:            alu_res = opnd_a + alu_b;
        endcase
    end

    // JAL links PC plus four
    assign result = id_ex_i.lui  ? id_ex_i.imm :
                    id_ex_i.jump ? id_ex_i.pc + 32'd4 : alu_res;

    assign taken = id_ex_i.jump || (id_ex_i.branch && ((opnd_a == opnd_b) != id_ex_i.bne));
    assign redirect_o    = id_ex_i.valid && taken;
    assign redirect_pc_o = id_ex_i.pc + id_ex_i.imm;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o.valid      <= id_ex_i.valid;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.reg_write  <= id_ex_i.reg_write;
            ex_mem_o.load       <= id_ex_i.load;
            ex_mem_o.store      <= id_ex_i.store;
            ex_mem_o.result     <= result;
            ex_mem_o.store_data <= opnd_b;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_stage.sv */
`default_nettype none

`include "rv32i_config.svh"

module fetch_stage (
    input  wire logic             clk,
    input  wire logic             arst_n_i,
    input  wire logic             stall_i,
    input  wire logic             redirect_i,
    input  wire logic [31:0]      redirect_pc_i,
    input  wire logic [31:0]      instr_i,
    output logic [31:0]           instr_addr_o,
    output rv32i_pkg::if_id_t     if_id_o
);

    logic [31:0] pc;

    assign instr_addr_o = pc;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc <= `RV_RESET_PC;
        end else if (redirect_i) begin
            pc <= redirect_pc_i;
        end else if (!stall_i) begin
            pc <= pc + 32'd4;
        end
    end

    // All-zero word decodes as an invalid opcode
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            if_id_o <= '0;
        end else if (redirect_i) begin
            if_id_o <= '0;
        end else if (!stall_i) begin
            if_id_o.instr <= instr_i;
            if_id_o.pc    <= pc;
        end
    end

endmodule

`default_nettype wire

/* verilog/hazard_unit.sv */
`default_nettype none

module hazard_unit (
    input  wire rv32i_pkg::id_ex_t  id_ex_i,
    input  wire rv32i_pkg::ex_mem_t ex_mem_i,
    input  wire rv32i_pkg::mem_wb_t mem_wb_i,
    input  wire logic [4:0]         rs1_id_i,
    input  wire logic [4:0]         rs2_id_i,
    output rv32i_pkg::fwd_sel_e     fwd_a_o,
    output rv32i_pkg::fwd_sel_e     fwd_b_o,
    output logic                    stall_o
);

    logic mem_writes;
    logic wb_writes;
    logic load_in_ex;

    assign mem_writes = ex_mem_i.valid && ex_mem_i.reg_write && (ex_mem_i.rd != 5'd0);
    assign wb_writes  = mem_wb_i.valid && mem_wb_i.reg_write && (mem_wb_i.rd != 5'd0);

    // Memory stage holds the newer result
    function automatic rv32i_pkg::fwd_sel_e pick(input logic [4:0] rs);
        if (mem_writes && (ex_mem_i.rd == rs)) return rv32i_pkg::FWD_MEM;
        if (wb_writes && (mem_wb_i.rd == rs)) return rv32i_pkg::FWD_WB;
        return rv32i_pkg::FWD_RF;
    endfunction

    always_comb begin
        fwd_a_o = pick(id_ex_i.rs1);
        fwd_b_o = pick(id_ex_i.rs2);
    end

    //////////////////////////////////////////////////
    // Load-use
    //////////////////////////////////////////////////

    assign load_in_ex = id_ex_i.valid && id_ex_i.load && (id_ex_i.rd != 5'd0);
    assign stall_o    = load_in_ex && ((id_ex_i.rd == rs1_id_i) || (id_ex_i.rd == rs2_id_i));

endmodule

`default_nettype wire

/* verilog/mem_wb_stage.sv */
`default_nettype none

module mem_wb_stage (
    input  wire logic               clk,
    input  wire logic               arst_n_i,
    input  wire rv32i_pkg::ex_mem_t ex_mem_i,
    input  wire logic [31:0]        data_rdata_i,
    output logic [31:0]             data_addr_o,
    output logic [31:0]             data_wdata_o,
    output logic                    data_we_o,
    output rv32i_pkg::mem_wb_t      mem_wb_o
);

    // Data port drives word accesses only
    assign data_addr_o  = ex_mem_i.result;
    assign data_wdata_o = ex_mem_i.store_data;
    assign data_we_o    = ex_mem_i.valid && ex_mem_i.store;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_wb_o <= '0;
        end else begin
            mem_wb_o.valid     <= ex_mem_i.valid;
            mem_wb_o.rd        <= ex_mem_i.rd;
            mem_wb_o.reg_write <= ex_mem_i.reg_write;
            mem_wb_o.value     <= ex_mem_i.load ? data_rdata_i : ex_mem_i.result;
        end
    end

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`default_nettype none

`include "rv32i_config.svh"

module register_file (
    input  wire logic               clk,
    input  wire logic               arst_n_i,
    input  wire logic [4:0]         rs1_i,
    input  wire logic [4:0]         rs2_i,
    input  wire rv32i_pkg::mem_wb_t wb_i,
    output logic [31:0]             rs1_data_o,
    output logic [31:0]             rs2_data_o
);

    logic [31:0] regs [1:`RV_NUM_REGS-1];
    logic        wr_en;

    assign wr_en = wb_i.valid && wb_i.reg_write && (wb_i.rd != 5'd0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.value;
        end
    end

    // x0 first, then same-cycle write
    function automatic logic [31:0] read_port(input logic [4:0] idx);
        if (idx == 5'd0) return '0;
        if (wr_en && (wb_i.rd == idx)) return wb_i.value;
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

`default_nettype wire

/* verilog/rv32i_config.svh */
`ifndef RV32I_CONFIG_SVH
`define RV32I_CONFIG_SVH

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Architectural registers, x0 included
`define RV_NUM_REGS 32

`endif

/* verilog/rv32i_core.sv */
`default_nettype none

module rv32i_core (
    input  wire logic        clk,
    input  wire logic        arst_n_i,
    input  wire logic [31:0] instr_i,
    input  wire logic [31:0] data_rdata_i,
    output logic [31:0]      instr_addr_o,
    output logic [31:0]      data_addr_o,
    output logic [31:0]      data_wdata_o,
    output logic             data_we_o
);

    rv32i_pkg::if_id_t   if_id;
    rv32i_pkg::id_ex_t   id_ex;
    rv32i_pkg::ex_mem_t  ex_mem;
    rv32i_pkg::mem_wb_t  mem_wb;
    rv32i_pkg::fwd_sel_e fwd_a;
    rv32i_pkg::fwd_sel_e fwd_b;
    logic                stall;
    logic                redirect;
    logic [31:0]         redirect_pc;
    logic [4:0]          rs1_id;
    logic [4:0]          rs2_id;

    //////////////////////////////////////////////////
    // Front end
    //////////////////////////////////////////////////

    fetch_stage u_fetch (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .instr_i       (instr_i),
        .instr_addr_o  (instr_addr_o),
        .if_id_o       (if_id)
    );

    decode_stage u_decode (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (stall),
        .flush_i  (redirect),
        .if_id_i  (if_id),
        .wb_i     (mem_wb),
        .id_ex_o  (id_ex),
        .rs1_o    (rs1_id),
        .rs2_o    (rs2_id)
    );

    hazard_unit u_hazard (
        .id_ex_i  (id_ex),
        .ex_mem_i (ex_mem),
        .mem_wb_i (mem_wb),
        .rs1_id_i (rs1_id),
        .rs2_id_i (rs2_id),
        .fwd_a_o  (fwd_a),
        .fwd_b_o  (fwd_b),
        .stall_o  (stall)
    );

    //////////////////////////////////////////////////
    // Back end
    //////////////////////////////////////////////////

    execute_stage u_execute (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .id_ex_i       (id_ex),
        .fwd_a_i       (fwd_a),
        .fwd_b_i       (fwd_b),
        .mem_fwd_i     (ex_mem.result),
        .wb_fwd_i      (mem_wb.value),
        .ex_mem_o      (ex_mem),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    mem_wb_stage u_mem_wb (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .ex_mem_i     (ex_mem),
        .data_rdata_i (data_rdata_i),
        .data_addr_o  (data_addr_o),
        .data_wdata_o (data_wdata_o),
        .data_we_o    (data_we_o),
        .mem_wb_o     (mem_wb)
    );

endmodule

`default_nettype wire

/* verilog/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

    // Register and I-type layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } ri_view_t;

    // S and B layout
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } sb_view_t;

    typedef union packed {
        ri_view_t ri;
        sb_view_t sb;
    } instr_u;

    //////////////////////////////////////////////////
    // Pipeline registers
    //////////////////////////////////////////////////

    typedef struct packed {
        instr_u      instr;
        logic [31:0] pc;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] imm;
        logic [31:0] pc;
        alu_op_e     alu_op;
        logic        use_imm;
        logic        load;
        logic        store;
        logic        branch;
        logic        bne;
        logic        jump;
        logic        lui;
        logic        reg_write;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic        reg_write;
        logic        load;
        logic        store;
        logic [31:0] result;
        logic [31:0] store_data;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic        reg_write;
        logic [31:0] value;
    } mem_wb_t;

endpackage

`default_nettype wire
